/* bench/udp_stream_tb.sv */
// Testbench with frame reference model, stream monitor, register checks and test sequence
`timescale 1ns/1ps
`include "udp_stream_cfg.svh"

module udp_stream_tb;

    typedef logic [64*`BANK_BEATS-1:0]  bank_bits_t;   // Beat j in bits 64j+63 to 64j
    typedef logic [64*`FRAME_BEATS-1:0] frame_bits_t;

    logic                      m00_axis_aclk;
    logic                      s00_axi_aresetn;
    logic                      in_valid;
    udp_stream_pkg::beat_t     in_data;
    logic                      m_tready;
    logic                      m_tvalid;
    udp_stream_pkg::beat_t     m_tdata;
    udp_stream_pkg::keep_t     m_tkeep;
    logic                      m_tlast;
    logic                      reg_wr;
    logic                      reg_rd;
    udp_stream_pkg::reg_addr_t reg_addr;
    udp_stream_pkg::reg_data_t reg_wdata;
    udp_stream_pkg::reg_data_t reg_rdata;
    logic                      reg_rvalid;

    integer                   seed = 32'hd9c8;
    integer                   rdy_seed = 32'hd9c8;   // Separate stream for back-pressure
    logic                     rand_ready = 1'b0;
    string                    test_name = "reset";
    udp_stream_pkg::net_cfg_t cfg_model;
    logic [31:0]              mac_stage;
    udp_stream_pkg::seq_t     seq_model = '0;
    int                       rcvd_model = 0;
    int                       frames_done = 0;
    int                       beat_idx = 0;
    frame_bits_t              exp_q[$];
    frame_bits_t              cur_frame;

    udp_stream_top UUT (.*);

    always #50 m00_axis_aclk = ~m00_axis_aclk;

    always @(negedge m00_axis_aclk) begin
        m_tready = rand_ready ? (($random(rdy_seed) & 3) != 0) : 1'b1;   // 75% ready
    end

    ////////////////////
    // Reference model
    function automatic frame_bits_t build_frame(input udp_stream_pkg::net_cfg_t c,
                                                input udp_stream_pkg::seq_t seq,
                                                input bank_bits_t bank);
        logic [7:0]  b [0:8*`FRAME_BEATS-1];
        logic [15:0] w [0:9];
        logic [31:0] sum;
        logic [47:0] smac;
        frame_bits_t f;
        int          i;
        smac = `SRC_MAC;
        w[0] = 16'h4500;
        w[1] = 16'(`IP_LEN);
        w[2] = 16'h0001;
        w[3] = 16'h4000;
        w[4] = 16'hFF11;
        w[5] = 16'h0000;
        w[6] = c.src_ip[31:16];
        w[7] = c.src_ip[15:0];
        w[8] = c.dst_ip[31:16];
        w[9] = c.dst_ip[15:0];
        sum = '0;
        for (i = 0; i < 10; i++) sum = sum + w[i];
        while (sum[31:16] != 0) sum = sum[15:0] + sum[31:16];   // Fold carries
        w[5] = ~sum[15:0];
        for (i = 0; i < 8*`FRAME_BEATS; i++) b[i] = 8'h00;
        for (i = 0; i < 6; i++) begin
            b[i]     = c.dst_mac[47-8*i -: 8];
            b[6 + i] = smac[47-8*i -: 8];
        end
        b[12] = 8'h08;
        for (i = 0; i < 10; i++) {b[14 + 2*i], b[15 + 2*i]} = w[i];
        {b[34], b[35]} = c.src_port;
        {b[36], b[37]} = c.dst_port;
        {b[38], b[39]} = 16'(`UDP_LEN);                  // UDP checksum stays zero
        for (i = 0; i < 8; i++) b[42 + i] = seq[8*i +: 8];  // Least significant first
        for (i = 0; i < 8*`BANK_BEATS; i++) b[50 + i] = bank[8*i +: 8];
        for (i = 0; i < 8*`FRAME_BEATS; i++) f[8*i +: 8] = b[i];
        return f;
    endfunction

    ////////////////////
    // Checks
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_beat(input string name, input udp_stream_pkg::beat_t exp_data,
                              input udp_stream_pkg::keep_t exp_keep, input logic exp_last,
                              input udp_stream_pkg::beat_t act_data,
                              input udp_stream_pkg::keep_t act_keep, input logic act_last);
        udp_stream_pkg::beat_t mask;
        int                    k;
        for (k = 0; k < 8; k++) mask[8*k +: 8] = {8{exp_keep[k]}};   // Ignore dead bytes
        if (((exp_data & mask) !== (act_data & mask)) || (exp_keep !== act_keep)
            || (exp_last !== act_last)) begin
            stop_on_error($sformatf({"Mismatch %s: expected data=%h keep=%h last=%b, ",
                                     "actual data=%h keep=%h last=%b"}, name, exp_data,
                                    exp_keep, exp_last, act_data, act_keep, act_last));
        end
    endtask

    task automatic check_reg(input string name, input udp_stream_pkg::reg_data_t exp_val,
                             input udp_stream_pkg::reg_data_t act_val);
        if (exp_val !== act_val)
            stop_on_error($sformatf("Mismatch %s: expected %h, actual %h",
                                    name, exp_val, act_val));
    endtask

    // Stream monitor, sampled on the handshake edge
    always @(posedge m00_axis_aclk) begin
        if (s00_axi_aresetn && m_tvalid && m_tready) begin
            if (beat_idx == 0) begin
                if (exp_q.size() == 0) stop_on_error("Output beat arrived with no frame due");
                cur_frame = exp_q.pop_front();
            end
            check_beat($sformatf("%s frame %0d beat %0d", test_name, frames_done + 1, beat_idx),
                       cur_frame[64*beat_idx +: 64],
                       (beat_idx == `FRAME_BEATS - 1) ? `LAST_KEEP : 8'hFF,
                       beat_idx == `FRAME_BEATS - 1, m_tdata, m_tkeep, m_tlast);
            if (beat_idx == `FRAME_BEATS - 1) begin
                beat_idx = 0;
                frames_done++;
            end else begin
                beat_idx++;
            end
        end
    end

    ////////////////////
    // Bus tasks
    task automatic reg_write(input udp_stream_pkg::reg_addr_t addr,
                             input udp_stream_pkg::reg_data_t data);
        @(negedge m00_axis_aclk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge m00_axis_aclk);
        reg_wr = 1'b0;
        // Expected configuration follows the register rules
        case (addr)
            `REG_DMAC_LO:  mac_stage = data;
            `REG_DMAC_HI:  cfg_model.dst_mac = {data[15:0], mac_stage};
            `REG_SRC_IP:   cfg_model.src_ip = data;
            `REG_DST_IP:   cfg_model.dst_ip = data;
            `REG_SRC_PORT: cfg_model.src_port = data[15:0];
            `REG_DST_PORT: cfg_model.dst_port = data[15:0];
            default: ;
        endcase
    endtask

    task automatic expect_reg(input string name, input udp_stream_pkg::reg_addr_t addr,
                              input udp_stream_pkg::reg_data_t exp_val);
        int cycles;
        @(negedge m00_axis_aclk);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge m00_axis_aclk);
        reg_rd = 1'b0;
        cycles = 0;
        while (!reg_rvalid) begin
            @(negedge m00_axis_aclk);
            cycles++;
            if (cycles > 10) stop_on_error($sformatf("Read of %s never returned", name));
        end
        check_reg({test_name, " ", name}, exp_val, reg_rdata);
    endtask

    task automatic expect_cfg_regs();
        expect_reg("DMAC_LO", `REG_DMAC_LO, cfg_model.dst_mac[31:0]);
        expect_reg("DMAC_HI", `REG_DMAC_HI, {16'h0000, cfg_model.dst_mac[47:32]});
        expect_reg("SRC_IP", `REG_SRC_IP, cfg_model.src_ip);
        expect_reg("DST_IP", `REG_DST_IP, cfg_model.dst_ip);
        expect_reg("SRC_PORT", `REG_SRC_PORT, {16'h0000, cfg_model.src_port});
        expect_reg("DST_PORT", `REG_DST_PORT, {16'h0000, cfg_model.dst_port});
    endtask

    // One bank of random samples, one beat every pace cycles
    task automatic send_bank(input int pace);
        bank_bits_t bank;
        int         i;
        for (i = 0; i < `BANK_BEATS; i++) bank[64*i +: 64] = {$random(seed), $random(seed)};
        seq_model++;
        exp_q.push_back(build_frame(cfg_model, seq_model, bank));
        for (i = 0; i < `BANK_BEATS; i++) begin
            @(negedge m00_axis_aclk);
            in_valid = 1'b1;
            in_data  = bank[64*i +: 64];
            @(negedge m00_axis_aclk);
            in_valid = 1'b0;
            repeat (pace - 2) @(negedge m00_axis_aclk);
            rcvd_model++;
        end
    endtask

    task automatic wait_frames(input int n);
        int cycles;
        cycles = 0;
        while (frames_done < n) begin
            @(negedge m00_axis_aclk);
            cycles++;
            if (cycles > 2000) stop_on_error($sformatf("Timeout waiting for frame %0d", n));
        end
    endtask

    ////////////////////
    // Test sequence
    initial begin
        m00_axis_aclk   = 1'b0;
        s00_axi_aresetn = 1'b0;
        in_valid        = 1'b0;
        in_data         = '0;
        m_tready        = 1'b1;
        reg_wr          = 1'b0;
        reg_rd          = 1'b0;
        reg_addr        = '0;
        reg_wdata       = '0;
        mac_stage       = '0;
        cfg_model       = '{`DEF_DST_MAC, `DEF_SRC_IP, `DEF_DST_IP, `DEF_PORT, `DEF_PORT};
        repeat (4) @(negedge m00_axis_aclk);
        s00_axi_aresetn = 1'b1;

        @(negedge m00_axis_aclk);
        if (m_tvalid !== 1'b0) stop_on_error("m_tvalid is not low after reset");
        expect_cfg_regs();
        expect_reg("SENT", `REG_SENT, 32'h0);
        expect_reg("RCVD", `REG_RCVD, 32'h0);
        expect_reg("unmapped", 6'h24, 32'h0);

        test_name = "default_two_banks";
        send_bank(4);
        send_bank(4);
        wait_frames(2);

        test_name = "new_config";
        reg_write(`REG_DMAC_LO, 32'h22334455);
        reg_write(`REG_DMAC_HI, 32'h00000211);
        reg_write(`REG_SRC_IP, 32'h0A000002);
        reg_write(`REG_DST_IP, 32'h0A000001);
        reg_write(`REG_SRC_PORT, 32'h000004D2);
        reg_write(`REG_DST_PORT, 32'h0000162E);
        expect_cfg_regs();
        send_bank(4);
        wait_frames(3);

        test_name = "mac_staging";
        reg_write(`REG_DMAC_LO, 32'hA1B2C3D4);       // Staged only
        expect_cfg_regs();
        send_bank(4);
        wait_frames(4);
        reg_write(`REG_DMAC_HI, 32'h00000E0F);
        expect_cfg_regs();
        send_bank(4);
        wait_frames(5);

        test_name  = "random_ready";
        rand_ready = 1'b1;
        repeat (4) send_bank(8);
        wait_frames(9);
        rand_ready = 1'b0;

        test_name = "counters";
        expect_reg("RCVD", `REG_RCVD, 32'(rcvd_model));
        expect_reg("SENT", `REG_SENT, seq_model[31:0]);

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* src/ctrl_regs.sv */
// Configuration registers, MAC staging, counters and read mux
`timescale 1ns/1ps
`include "udp_stream_cfg.svh"

module ctrl_regs (
    input  logic                      m00_axis_aclk,
    input  logic                      s00_axi_aresetn,
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  udp_stream_pkg::reg_addr_t reg_addr,
    input  udp_stream_pkg::reg_data_t reg_wdata,
    output udp_stream_pkg::reg_data_t reg_rdata,
    output logic                      reg_rvalid,
    input  logic                      in_valid,
    input  udp_stream_pkg::seq_t      sent,
    output udp_stream_pkg::net_cfg_t  cfg
);

    logic [31:0]               mac_lo;    // MAC bytes 2 to 5 awaiting commit
    logic [31:0]               rcvd;
    udp_stream_pkg::reg_data_t rd_mux;

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            cfg.dst_mac  <= `DEF_DST_MAC;
            cfg.src_ip   <= `DEF_SRC_IP;
            cfg.dst_ip   <= `DEF_DST_IP;
            cfg.src_port <= `DEF_PORT;
            cfg.dst_port <= `DEF_PORT;
            mac_lo       <= '0;
            rcvd         <= '0;
            reg_rvalid   <= 1'b0;
        end else begin
            if (in_valid) rcvd <= rcvd + 1'b1;  // Dropped beats count too
            reg_rvalid <= reg_rd;
            if (reg_wr) begin
                case (reg_addr)
                    `REG_DMAC_LO:  mac_lo       <= reg_wdata;
                    `REG_DMAC_HI:  cfg.dst_mac  <= {reg_wdata[15:0], mac_lo};
                    `REG_SRC_IP:   cfg.src_ip   <= reg_wdata;
                    `REG_DST_IP:   cfg.dst_ip   <= reg_wdata;
                    `REG_SRC_PORT: cfg.src_port <= reg_wdata[15:0];
                    `REG_DST_PORT: cfg.dst_port <= reg_wdata[15:0];
                    default: ;
                endcase
            end
        end
    end

    ////////////////////
    // Readback
    always_comb begin
        case (reg_addr)
            `REG_SENT:     rd_mux = sent[31:0];
            `REG_RCVD:     rd_mux = rcvd;
            `REG_DMAC_LO:  rd_mux = cfg.dst_mac[31:0];          // Committed value only
            `REG_DMAC_HI:  rd_mux = {16'h0000, cfg.dst_mac[47:32]};
            `REG_SRC_IP:   rd_mux = cfg.src_ip;
            `REG_DST_IP:   rd_mux = cfg.dst_ip;
            `REG_SRC_PORT: rd_mux = {16'h0000, cfg.src_port};
            `REG_DST_PORT: rd_mux = {16'h0000, cfg.dst_port};
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge m00_axis_aclk) begin
        if (reg_rd) reg_rdata <= rd_mux;
    end

endmodule

/* src/header_builder.sv */
// Header snapshot with fixed fields, lengths and IPv4 header checksum
`timescale 1ns/1ps
`include "udp_stream_cfg.svh"

module header_builder (
    input  logic                     m00_axis_aclk,
    input  logic                     s00_axi_aresetn,
    input  udp_stream_pkg::net_cfg_t cfg,
    input  logic                     take,
    output udp_stream_pkg::hdr_t     hdr
);

    localparam logic [15:0] IP_LEN16  = 16'(`IP_LEN);
    localparam logic [15:0] UDP_LEN16 = 16'(`UDP_LEN);

    function automatic udp_stream_pkg::hdr_t build_hdr(input udp_stream_pkg::net_cfg_t c);
        udp_stream_pkg::hdr_t h;
        logic [9:0][15:0]     ip_w;   // Word 9 goes first
        logic [31:0]          sum;
        ip_w = {16'h4500, IP_LEN16, 16'h0001, 16'h4000, 16'hFF11, 16'h0000,
                c.src_ip, c.dst_ip};
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 32'(ip_w[i]);
        end
        // Two folds absorb every carry of ten words
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        ip_w[4] = ~sum[15:0];           // Checksum field
        h[5:0]   = {<<8{c.dst_mac}};
        h[11:6]  = {<<8{`SRC_MAC}};
        h[13:12] = {<<8{16'h0800}};     // IPv4 EtherType
        h[33:14] = {<<8{ip_w}};
        h[41:34] = {<<8{c.src_port, c.dst_port, UDP_LEN16, 16'h0000}};
        return h;
    endfunction

    localparam udp_stream_pkg::net_cfg_t DEF_CFG = '{
        dst_mac:  `DEF_DST_MAC,
        src_ip:   `DEF_SRC_IP,
        dst_ip:   `DEF_DST_IP,
        src_port: `DEF_PORT,
        dst_port: `DEF_PORT
    };
    localparam udp_stream_pkg::hdr_t DEF_HDR = build_hdr(DEF_CFG);

    // Snapshot so that config writes during a frame wait for the next one
    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) hdr <= DEF_HDR;
        else if (take)        hdr <= build_hdr(cfg);
    end

endmodule

/* src/payload_if.sv */
// Payload hand-off interface between the sample buffer and the framer
`timescale 1ns/1ps

interface payload_if;
    logic                  avail;    // A full bank waits to be sent
    logic                  take;     // Framer claims the waiting bank
    logic                  rd_en;
    udp_stream_pkg::beat_t rd_data;  // One cycle after rd_en
    logic                  rd_last;  // Last beat of the bank

    modport buffer (
        output avail, rd_data, rd_last,
        input  take, rd_en
    );

    modport framer (
        input  avail, rd_data, rd_last,
        output take, rd_en
    );
endinterface

/* src/sample_pingpong.sv */
// Two-bank sample buffer with write steering and bank hand-off
`timescale 1ns/1ps
`include "udp_stream_cfg.svh"

module sample_pingpong (
    input  logic                  m00_axis_aclk,
    input  logic                  s00_axi_aresetn,
    input  logic                  in_valid,
    input  udp_stream_pkg::beat_t in_data,
    payload_if.buffer             pl
);

    localparam int PTR_W = $clog2(`BANK_BEATS);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`BANK_BEATS - 1);

    udp_stream_pkg::beat_t mem [0:1][0:`BANK_BEATS-1];

    logic             wr_bank;
    logic [PTR_W-1:0] wr_ptr;
    logic [1:0]       full;
    logic             rd_bank;
    logic [PTR_W-1:0] rd_ptr;
    logic             active;   // Read bank claimed by the framer
    logic             wr_en;

    assign wr_en    = in_valid && !full[wr_bank];    // Drop beats while the bank is busy
    assign pl.avail = full[rd_bank] && !active;

    always_ff @(posedge m00_axis_aclk) begin
        if (wr_en) mem[wr_bank][wr_ptr] <= in_data;
        if (pl.rd_en) pl.rd_data <= mem[rd_bank][rd_ptr];
    end

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            wr_bank    <= 1'b0;
            wr_ptr     <= '0;
            full       <= 2'b00;
            rd_bank    <= 1'b0;
            rd_ptr     <= '0;
            active     <= 1'b0;
            pl.rd_last <= 1'b0;
        end else begin
            pl.rd_last <= pl.rd_en && (rd_ptr == LAST_PTR);
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (wr_ptr == LAST_PTR) begin      // Bank complete, swap
                    full[wr_bank] <= 1'b1;
                    wr_bank       <= ~wr_bank;
                    wr_ptr        <= '0;
                end
            end
            if (pl.take) active <= 1'b1;
            if (pl.rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (rd_ptr == LAST_PTR) begin
                    // Last beat out frees the bank
                    full[rd_bank] <= 1'b0;
                    rd_bank       <= ~rd_bank;
                    rd_ptr        <= '0;
                    active        <= 1'b0;
                end
            end
        end
    end

    ////////////////////
    // Checks
    take_while_avail: assert property (@(posedge m00_axis_aclk) disable iff (!s00_axi_aresetn)
        pl.take |-> pl.avail);

    no_write_into_sent_bank: assert property (@(posedge m00_axis_aclk)
        disable iff (!s00_axi_aresetn)
        wr_en |-> !(active && (wr_bank == rd_bank)));

endmodule

/* src/udp_framer.sv */
// Frame sequencer with payload alignment, sequence counter and stream output register
`timescale 1ns/1ps
`include "udp_stream_cfg.svh"

module udp_framer (
    input  logic                  m00_axis_aclk,
    input  logic                  s00_axi_aresetn,
    input  udp_stream_pkg::hdr_t  hdr,
    payload_if.framer             pl,
    input  logic                  m_tready,
    output logic                  m_tvalid,
    output udp_stream_pkg::beat_t m_tdata,
    output udp_stream_pkg::keep_t m_tkeep,
    output logic                  m_tlast,
    output udp_stream_pkg::seq_t  sent
);

    localparam int IDX_W = $clog2(`FRAME_BEATS);
    localparam logic [IDX_W-1:0] SEQ_IDX   = IDX_W'(5);   // UDP checksum + sequence
    localparam logic [IDX_W-1:0] PAY_FIRST = IDX_W'(6);
    localparam logic [IDX_W-1:0] TAIL_IDX  = IDX_W'(`FRAME_BEATS - 1);

    logic                  busy;
    logic [IDX_W-1:0]      idx;
    logic                  rd_pend;    // Bank beat arrives this cycle
    logic                  out_ready;
    logic                  hdr_load;
    logic                  pay_load;
    logic                  tail_load;
    logic [2:0]            hdr_sel;
    udp_stream_pkg::beat_t head_beat;
    logic [15:0]           prev_hi;    // Upper word carried into the next beat

    assign out_ready = !m_tvalid || m_tready;
    assign pl.take   = !busy && pl.avail;
    assign hdr_load  = busy && (idx <= SEQ_IDX) && out_ready;
    assign pay_load  = rd_pend;        // Output was free when the read went out
    assign tail_load = busy && (idx == TAIL_IDX) && out_ready;
    // Read only if the beat can be taken on arrival
    assign pl.rd_en  = busy && (idx >= PAY_FIRST) && (idx < TAIL_IDX)
                       && !rd_pend && out_ready;

    assign hdr_sel = (idx < SEQ_IDX) ? idx[2:0] : 3'd0;

    always_comb begin
        if (idx == SEQ_IDX) head_beat = {sent[47:0], hdr[41], hdr[40]};
        else                head_beat = hdr[8*hdr_sel +: 8];
    end

    ////////////////////
    // Control
    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            busy     <= 1'b0;
            idx      <= '0;
            rd_pend  <= 1'b0;
            sent     <= '0;
            m_tvalid <= 1'b0;
            m_tkeep  <= '1;
            m_tlast  <= 1'b0;
        end else begin
            rd_pend <= pl.rd_en;
            if (pl.take) begin
                busy <= 1'b1;
                idx  <= '0;
                sent <= sent + 1'b1;    // First frame carries 1
            end
            if (hdr_load || pay_load || tail_load) begin
                m_tvalid <= 1'b1;
                m_tkeep  <= tail_load ? `LAST_KEEP : 8'hFF;
                m_tlast  <= tail_load;
            end else if (m_tready) begin
                m_tvalid <= 1'b0;
            end
            if (hdr_load) idx <= idx + 1'b1;
            if (pay_load) idx <= pl.rd_last ? TAIL_IDX : idx + 1'b1;
            if (tail_load) busy <= 1'b0;
        end
    end

    ////////////////////
    // Data path
    always_ff @(posedge m00_axis_aclk) begin
        if (hdr_load) begin
            m_tdata <= head_beat;
            if (idx == SEQ_IDX) prev_hi <= sent[63:48];
        end else if (pay_load) begin
            m_tdata <= {pl.rd_data[47:0], prev_hi};   // 16-bit shift from the 50-byte preamble
            prev_hi <= pl.rd_data[63:48];
        end else if (tail_load) begin
            m_tdata <= {48'h0, prev_hi};
        end
    end

    hold_while_stalled: assert property (@(posedge m00_axis_aclk)
        disable iff (!s00_axi_aresetn)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tkeep)
                                     && $stable(m_tlast)));

endmodule

/* src/udp_stream_cfg.svh */
// Frame sizes, network defaults and control register offsets
`ifndef UDP_STREAM_CFG_SVH
`define UDP_STREAM_CFG_SVH

////////////////////
// Frame geometry
`define PAYLOAD_WORDS   32                          // 16-bit words per packet
`define BEAT_BYTES      8
`define BANK_BEATS      (`PAYLOAD_WORDS / 4)        // 4 words per beat
`define UDP_LEN         (8 + 8 + 2 * `PAYLOAD_WORDS) // UDP header + sequence + payload
`define IP_LEN          (20 + `UDP_LEN)
`define FRAME_BEATS     (`BANK_BEATS + 7)
`define LAST_KEEP       8'h03                       // Two bytes left after the shift

////////////////////
// Network defaults
`define SRC_MAC         48'h001A2B3C4D5E
`define DEF_DST_MAC     48'hFFFFFFFFFFFF            // Broadcast
`define DEF_SRC_IP      32'hC0A80463                // 192.168.4.99
`define DEF_DST_IP      32'hC0A80401                // 192.168.4.1
`define DEF_PORT        16'd60133

////////////////////
// Register map
`define REG_SENT        6'h04
`define REG_RCVD        6'h08
`define REG_DMAC_LO     6'h0C
`define REG_DMAC_HI     6'h10
`define REG_SRC_IP      6'h14
`define REG_DST_IP      6'h18
`define REG_SRC_PORT    6'h1C
`define REG_DST_PORT    6'h20

`endif

/* src/udp_stream_pkg.sv */
// Stream beat, network address, header and register types
package udp_stream_pkg;

    // Byte n of the wire sits in bits 8n+7 to 8n
    typedef logic [63:0] beat_t;
    typedef logic [7:0]  keep_t;

    // Addresses and ports, most significant byte first on the wire
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] port_t;

    typedef logic [63:0] seq_t;     // Packet sequence number

    typedef struct packed {
        mac_t  dst_mac;
        ip_t   src_ip;
        ip_t   dst_ip;
        port_t src_port;
        port_t dst_port;
    } net_cfg_t;

    // Ethernet, IPv4 and UDP headers, element 0 is the first byte sent
    typedef logic [41:0][7:0] hdr_t;

    // Control register port
    typedef logic [5:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

endpackage

/* src/udp_stream_top.sv */
// Top level of the ADC sample to UDP frame streamer
`timescale 1ns/1ps

module udp_stream_top (
    input  logic                      m00_axis_aclk,
    input  logic                      s00_axi_aresetn,
    // Sample input, always accepted
    input  logic                      in_valid,
    input  udp_stream_pkg::beat_t     in_data,
    // Frame output
    input  logic                      m_tready,
    output logic                      m_tvalid,
    output udp_stream_pkg::beat_t     m_tdata,
    output udp_stream_pkg::keep_t     m_tkeep,
    output logic                      m_tlast,
    // Control registers
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  udp_stream_pkg::reg_addr_t reg_addr,
    input  udp_stream_pkg::reg_data_t reg_wdata,
    output udp_stream_pkg::reg_data_t reg_rdata,
    output logic                      reg_rvalid
);

    udp_stream_pkg::net_cfg_t cfg;
    udp_stream_pkg::hdr_t     hdr;
    udp_stream_pkg::seq_t     sent;

    payload_if pl ();

    sample_pingpong u_pingpong (
        .m00_axis_aclk  (m00_axis_aclk),
        .s00_axi_aresetn(s00_axi_aresetn),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .pl             (pl.buffer)
    );

    header_builder u_header (
        .m00_axis_aclk  (m00_axis_aclk),
        .s00_axi_aresetn(s00_axi_aresetn),
        .cfg            (cfg),
        .take           (pl.take),      // Snapshot as the bank is claimed
        .hdr            (hdr)
    );

    udp_framer u_framer (
        .m00_axis_aclk  (m00_axis_aclk),
        .s00_axi_aresetn(s00_axi_aresetn),
        .hdr            (hdr),
        .pl             (pl.framer),
        .m_tready       (m_tready),
        .m_tvalid       (m_tvalid),
        .m_tdata        (m_tdata),
        .m_tkeep        (m_tkeep),
        .m_tlast        (m_tlast),
        .sent           (sent)
    );

    ctrl_regs u_regs (
        .m00_axis_aclk  (m00_axis_aclk),
        .s00_axi_aresetn(s00_axi_aresetn),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .reg_rvalid     (reg_rvalid),
        .in_valid       (in_valid),
        .sent           (sent),
        .cfg            (cfg)
    );

endmodule

/* vlog.f */
+incdir+src
src/udp_stream_pkg.sv
src/payload_if.sv
src/sample_pingpong.sv
src/header_builder.sv
src/udp_framer.sv
src/ctrl_regs.sv
src/udp_stream_top.sv
bench/udp_stream_tb.sv
